// ==== common/dm_consts.svh ====
`ifndef DM_CONSTS_SVH
`define DM_CONSTS_SVH

// ---------------------------------------------------------------------------
// sizing
// ---------------------------------------------------------------------------

// harts served by this debug memory
`define DM_NR_HARTS 4
// index width of a hart, at least one bit
`define DM_HART_BITS ((`DM_NR_HARTS > 1) ? $clog2(`DM_NR_HARTS) : 1)

`define DM_DATA_COUNT 2
`define DM_PROGBUF_SIZE 8
// words of the generated abstract-command program
`define DM_ABSCMD_WORDS 10

// only the low part of the bus address is decoded
`define DM_ADDR_BITS 12
`define DM_BUS_WIDTH 32

// ---------------------------------------------------------------------------
// debug address map
// ---------------------------------------------------------------------------

// hart-written status strobes
`define DM_HALTED_ADDR 12'h100
`define DM_GOING_ADDR 12'h104
`define DM_RESUMING_ADDR 12'h108
`define DM_EXCEPTION_ADDR 12'h10C

// jump slot read by the park loop
`define DM_WHERETO_ADDR 12'h300
// abstract program sits right below the program buffer
`define DM_ABSCMD_ADDR 12'h338
`define DM_PROGBUF_ADDR 12'h360
`define DM_DATA_ADDR 12'h380
// one flag byte per hart up to 'h7FF
`define DM_FLAGS_ADDR 12'h400
`define DM_RESUME_ADDR 12'h804

`endif

// ==== common/dm_pkg.sv ====
package dm_pkg;

  // abstract command kinds, only access register is served here
  typedef enum logic [7:0] {
    AccessRegister = 8'h0,
    QuickAccess    = 8'h1,
    AccessMemory   = 8'h2
  } cmdtype_e;

  typedef struct packed {
    cmdtype_e    cmdtype;
    logic [23:0] control;
  } command_t;

  // control field of an access register command
  typedef struct packed {
    logic        zero1;
    logic [2:0]  aarsize;
    logic        aarpostincrement;
    logic        postexec;
    logic        transfer;
    logic        write;
    logic [15:0] regno;
  } ac_ar_cmd_t;

  // abstractcs cmderr encoding
  typedef enum logic [2:0] {
    CmdErrNone         = 3'd0,
    CmdErrNotSupported = 3'd2,
    CmdErrException    = 3'd3,
    CmdErrHaltResume   = 3'd4
  } cmderr_e;

  typedef enum logic [1:0] {
    Idle,
    Go,
    Resume,
    CmdExecuting
  } hart_state_e;

  typedef logic [31:0] word_t;

  // ---------------------------------------------------------------------------
  // rv32 instruction encodings
  // ---------------------------------------------------------------------------

  // jal with rd = x0, imm is a byte offset
  function automatic word_t enc_jal_x0(input logic [20:0] imm);
    return {imm[20], imm[10:1], imm[11], imm[19:12], 5'd0, 7'h6f};
  endfunction

  // size maps straight onto funct3 of lb/lh/lw
  function automatic word_t enc_load(input logic [2:0] size, input logic [4:0] dest,
                                     input logic [4:0] base, input logic [11:0] offset);
    return {offset, base, size, dest, 7'h03};
  endfunction

  function automatic word_t enc_store(input logic [2:0] size, input logic [4:0] src,
                                      input logic [4:0] base, input logic [11:0] offset);
    return {offset[11:5], src, base, size, offset[4:0], 7'h23};
  endfunction

  // addi x0, x0, 0
  function automatic word_t enc_nop();
    return 32'h0000_0013;
  endfunction

  function automatic word_t enc_ebreak();
    return 32'h0010_0073;
  endfunction

  // all zero is a defined illegal instruction
  function automatic word_t enc_illegal();
    return 32'h0000_0000;
  endfunction

endpackage

// ==== hart_ctrl/dm_hart_flags.sv ====
`timescale 1ns/10ps

module dm_hart_flags #(
  parameter bit Selectable = 1'b1
) (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic halted_set_i,
  input  logic resuming_set_i,
  input  logic resumeack_clr_i,
  output logic halted_o,
  output logic resuming_o
);

  logic halted_d;
  logic resuming_d;

  always_comb begin : p_next
    halted_d   = halted_o;
    resuming_d = resuming_o;
    // ack cleared by the debugger once it saw the resume
    if (resumeack_clr_i) begin
      resuming_d = 1'b0;
    end
    if (halted_set_i) begin
      halted_d = 1'b1;
    end
    // hart left the park loop
    // resuming write beats a clear in the same cycle
    if (resuming_set_i) begin
      halted_d   = 1'b0;
      resuming_d = 1'b1;
    end
  end

  // harts that cannot be selected never report status
  always_ff @(posedge clk_i or negedge rst_ni) begin : p_flags
    if (!rst_ni) begin
      halted_o   <= 1'b0;
      resuming_o <= 1'b0;
    end else begin
      halted_o   <= Selectable & halted_d;
      resuming_o <= Selectable & resuming_d;
    end
  end

endmodule

// ==== hart_ctrl/dm_hart_ctrl_fsm.sv ====
`timescale 1ns/10ps
`include "dm_consts.svh"

module dm_hart_ctrl_fsm (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic [`DM_HART_BITS-1:0] hartsel_i,
  input  logic                     cmd_valid_i,
  input  logic                     unsupported_i,
  input  logic [`DM_NR_HARTS-1:0]  halted_i,
  input  logic [`DM_NR_HARTS-1:0]  halted_set_i,
  input  logic [`DM_NR_HARTS-1:0]  resuming_i,
  input  logic [`DM_NR_HARTS-1:0]  haltreq_i,
  input  logic [`DM_NR_HARTS-1:0]  resumereq_i,
  input  logic                     going_i,
  input  logic                     exception_i,
  output logic                     cmdbusy_o,
  output logic                     go_o,
  output logic                     resume_o,
  output logic                     cmderror_valid_o,
  output dm_pkg::cmderr_e          cmderror_o
);
  import dm_pkg::*;

  hart_state_e state_d, state_q;

  // levels decoded from the state
  // busy only while a program is scheduled or running
  assign go_o      = (state_q == Go);
  assign resume_o  = (state_q == Resume);
  assign cmdbusy_o = (state_q == Go) || (state_q == CmdExecuting);

  always_comb begin : p_next
    state_d          = state_q;
    cmderror_valid_o = 1'b0;
    cmderror_o       = CmdErrNone;

    case (state_q)
      Idle: begin
        if (cmd_valid_i && halted_i[hartsel_i] && !unsupported_i) begin
          // hand the command to the parked hart
          state_d = Go;
        end else if (cmd_valid_i) begin
          // commands need a halted hart
          cmderror_valid_o = 1'b1;
          cmderror_o       = CmdErrHaltResume;
        end
        // resume ignored while a halt is pending or the ack is still set
        if (resumereq_i[hartsel_i] && !resuming_i[hartsel_i] &&
            !haltreq_i[hartsel_i] && halted_i[hartsel_i]) begin
          state_d = Resume;
        end
      end
      // wait for the hart to pick up the go flag
      Go: begin
        if (going_i) begin
          state_d = CmdExecuting;
        end
      end
      // program ends with ebreak, hart reports halted again
      CmdExecuting: begin
        if (halted_set_i[hartsel_i]) begin
          state_d = Idle;
        end
      end
      Resume: begin
        if (resuming_i[hartsel_i]) begin
          state_d = Idle;
        end
      end
      default: state_d = Idle;
    endcase

    // reported once with the command so cmderr can be cleared afterwards
    if (unsupported_i && cmd_valid_i) begin
      cmderror_valid_o = 1'b1;
      cmderror_o       = CmdErrNotSupported;
    end
    // exception during the program wins
    if (exception_i) begin
      cmderror_valid_o = 1'b1;
      cmderror_o       = CmdErrException;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin : p_state
    if (!rst_ni) begin
      state_q <= Idle;
    end else begin
      state_q <= state_d;
    end
  end

endmodule

// ==== hw/dm_prog_gen.sv ====
`timescale 1ns/10ps
`include "dm_consts.svh"

module dm_prog_gen (
  input  dm_pkg::command_t                     cmd_i,
  output dm_pkg::word_t [`DM_ABSCMD_WORDS-1:0] prog_o,
  output logic                                 unsupported_o,
  output logic                                 jump_progbuf_o
);
  import dm_pkg::*;

  localparam int unsigned LastWord = `DM_ABSCMD_WORDS - 1;

  ac_ar_cmd_t ac_ar;

  assign ac_ar = ac_ar_cmd_t'(cmd_i.control);

  // no transfer but postexec: whereto jumps straight into the program buffer
  assign jump_progbuf_o = (cmd_i.cmdtype == AccessRegister) &&
                          !ac_ar.transfer && ac_ar.postexec;

  always_comb begin : p_prog
    for (int i = 0; i < `DM_ABSCMD_WORDS; i++) begin
      prog_o[i] = enc_nop();
    end
    // without a transfer the program must not be entered
    prog_o[0]        = ac_ar.transfer ? enc_nop() : enc_illegal();
    prog_o[LastWord] = enc_ebreak();
    unsupported_o    = 1'b0;

    if (cmd_i.cmdtype != AccessRegister) begin
      unsupported_o = 1'b1;
    end else if (ac_ar.aarsize >= 3'd3 || ac_ar.aarpostincrement) begin
      // only up to 32 bit, no auto increment
      unsupported_o = 1'b1;
    end else if (ac_ar.transfer) begin
      // reserved range, csr (regno[12] low) and fpr (regno[5] high)
      if (ac_ar.regno[15:14] != 2'b00 || !ac_ar.regno[12] || ac_ar.regno[5]) begin
        unsupported_o = 1'b1;
      end else if (ac_ar.write) begin
        // data register into gpr, x0 base works from the zero page
        prog_o[1] = enc_load(ac_ar.aarsize, ac_ar.regno[4:0], 5'd0,
                             12'(`DM_DATA_ADDR));
      end else begin
        // gpr into data register
        prog_o[1] = enc_store(ac_ar.aarsize, ac_ar.regno[4:0], 5'd0,
                              12'(`DM_DATA_ADDR));
      end
    end

    if (unsupported_o) begin
      // leave at once
      prog_o[0] = enc_ebreak();
    end else if (ac_ar.postexec) begin
      // fall through into the program buffer
      prog_o[LastWord] = enc_nop();
    end
  end

endmodule

// ==== hw/dm_mem_decode.sv ====
`timescale 1ns/10ps
`include "dm_consts.svh"

module dm_mem_decode (
  input  logic                                 clk_i,
  input  logic                                 rst_ni,
  input  logic                                 req_i,
  input  logic                                 we_i,
  input  logic [`DM_BUS_WIDTH-1:0]             addr_i,
  input  logic [`DM_BUS_WIDTH-1:0]             wdata_i,
  input  logic [`DM_BUS_WIDTH/8-1:0]           be_i,
  input  logic [`DM_HART_BITS-1:0]             hartsel_i,
  input  logic                                 clear_resumeack_i,
  input  dm_pkg::word_t [`DM_DATA_COUNT-1:0]   data_i,
  input  dm_pkg::word_t [`DM_PROGBUF_SIZE-1:0] progbuf_i,
  input  dm_pkg::word_t [`DM_ABSCMD_WORDS-1:0] prog_i,
  input  logic                                 jump_progbuf_i,
  input  logic                                 cmdbusy_i,
  input  logic                                 go_i,
  input  logic                                 resume_i,
  input  logic [`DM_NR_HARTS-1:0]              resumereq_i,
  output logic [`DM_NR_HARTS-1:0]              halted_set_o,
  output logic [`DM_NR_HARTS-1:0]              resuming_set_o,
  output logic [`DM_NR_HARTS-1:0]              resumeack_clr_o,
  output logic                                 going_o,
  output logic                                 exception_o,
  output dm_pkg::word_t [`DM_DATA_COUNT-1:0]   data_o,
  output logic                                 data_valid_o,
  output logic [`DM_BUS_WIDTH-1:0]             rdata_o
);
  import dm_pkg::*;

  localparam int unsigned AW          = `DM_ADDR_BITS;
  localparam int unsigned DataIdxBits = (`DM_DATA_COUNT > 1) ? $clog2(`DM_DATA_COUNT) : 1;
  localparam int unsigned ProgIdxBits = $clog2(`DM_PROGBUF_SIZE);
  localparam int unsigned AbsIdxBits  = $clog2(`DM_ABSCMD_WORDS);

  // last byte of each region
  localparam logic [AW-1:0] DataEnd  = AW'(`DM_DATA_ADDR + 4 * `DM_DATA_COUNT - 1);
  localparam logic [AW-1:0] ProgEnd  = AW'(`DM_PROGBUF_ADDR + 4 * `DM_PROGBUF_SIZE - 1);
  localparam logic [AW-1:0] AbsEnd   = AW'(`DM_ABSCMD_ADDR + 4 * `DM_ABSCMD_WORDS - 1);
  localparam logic [AW-1:0] FlagsEnd = AW'(`DM_FLAGS_ADDR + 12'h3FF);

  logic [AW-1:0]            addr;
  logic [`DM_HART_BITS-1:0] wdata_hartsel;
  logic [DataIdxBits-1:0]   data_idx;
  logic [ProgIdxBits-1:0]   prog_idx;
  logic [AbsIdxBits-1:0]    abs_idx;
  logic [3:0][7:0]          flag_bytes;
  word_t                    rdata_d, rdata_q;

  assign addr          = addr_i[AW-1:0];
  // harts put their own index into wdata on status writes
  assign wdata_hartsel = wdata_i[`DM_HART_BITS-1:0];

  // word index inside each region
  assign data_idx = DataIdxBits'((addr - AW'(`DM_DATA_ADDR)) >> 2);
  assign prog_idx = ProgIdxBits'((addr - AW'(`DM_PROGBUF_ADDR)) >> 2);
  assign abs_idx  = AbsIdxBits'((addr - AW'(`DM_ABSCMD_ADDR)) >> 2);

  // ---------------------------------------------------------------------------
  // write side, strobes and data merge
  // ---------------------------------------------------------------------------

  always_comb begin : p_write
    halted_set_o    = '0;
    resuming_set_o  = '0;
    resumeack_clr_o = '0;
    going_o         = 1'b0;
    exception_o     = 1'b0;
    data_valid_o    = 1'b0;
    data_o          = data_i;

    if (clear_resumeack_i) begin
      resumeack_clr_o[hartsel_i] = 1'b1;
    end

    if (req_i && we_i) begin
      case (addr) inside
        `DM_HALTED_ADDR:    halted_set_o[wdata_hartsel] = 1'b1;
        `DM_GOING_ADDR:     going_o = 1'b1;
        `DM_RESUMING_ADDR:  resuming_set_o[wdata_hartsel] = 1'b1;
        `DM_EXCEPTION_ADDR: exception_o = 1'b1;
        // hart writes a data register, only enabled bytes change
        [`DM_DATA_ADDR:DataEnd]: begin
          data_valid_o = 1'b1;
          for (int i = 0; i < `DM_BUS_WIDTH / 8; i++) begin
            if (be_i[i]) begin
              data_o[data_idx][i*8 +: 8] = wdata_i[i*8 +: 8];
            end
          end
        end
        default: ;
      endcase
    end
  end

  // ---------------------------------------------------------------------------
  // read side, registered mux
  // ---------------------------------------------------------------------------

  always_comb begin : p_read
    rdata_d    = rdata_q;
    flag_bytes = '0;

    if (req_i && !we_i) begin
      case (addr) inside
        `DM_WHERETO_ADDR: begin
          if (resumereq_i[hartsel_i]) begin
            rdata_d = enc_jal_x0(21'(`DM_RESUME_ADDR) - 21'(`DM_WHERETO_ADDR));
          end
          // a running command takes priority over resume
          if (cmdbusy_i) begin
            if (jump_progbuf_i) begin
              rdata_d = enc_jal_x0(21'(`DM_PROGBUF_ADDR) - 21'(`DM_WHERETO_ADDR));
            end else begin
              rdata_d = enc_jal_x0(21'(`DM_ABSCMD_ADDR) - 21'(`DM_WHERETO_ADDR));
            end
          end
        end
        [`DM_DATA_ADDR:DataEnd]:    rdata_d = data_i[data_idx];
        [`DM_PROGBUF_ADDR:ProgEnd]: rdata_d = progbuf_i[prog_idx];
        [`DM_ABSCMD_ADDR:AbsEnd]:   rdata_d = prog_i[abs_idx];
        // park loop polls its flag byte
        // only the selected hart sees go/resume
        [`DM_FLAGS_ADDR:FlagsEnd]: begin
          if (({addr[AW-1:2], 2'b00} - AW'(`DM_FLAGS_ADDR)) ==
              (AW'(hartsel_i) & ~AW'(3))) begin
            flag_bytes[2'(hartsel_i)] = {6'b0, resume_i, go_i};
          end
          rdata_d = flag_bytes;
        end
        default: ;
      endcase
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin : p_rdata
    if (!rst_ni) begin
      rdata_q <= '0;
    end else begin
      rdata_q <= rdata_d;
    end
  end

  assign rdata_o = rdata_q;

endmodule

// ==== hw/dm_mem_top.sv ====
`timescale 1ns/10ps
`include "dm_consts.svh"

module dm_mem_top (
  input  logic                                  clk_i,
  input  logic                                  rst_ni,
  input  logic [19:0]                           hartsel_i,
  input  logic [`DM_NR_HARTS-1:0]               haltreq_i,
  input  logic [`DM_NR_HARTS-1:0]               resumereq_i,
  input  logic                                  clear_resumeack_i,
  input  dm_pkg::word_t [`DM_PROGBUF_SIZE-1:0]  progbuf_i,
  input  dm_pkg::word_t [`DM_DATA_COUNT-1:0]    data_i,
  input  logic                                  cmd_valid_i,
  input  dm_pkg::command_t                      cmd_i,
  input  logic                                  req_i,
  input  logic                                  we_i,
  input  logic [`DM_BUS_WIDTH-1:0]              addr_i,
  input  logic [`DM_BUS_WIDTH-1:0]              wdata_i,
  input  logic [`DM_BUS_WIDTH/8-1:0]            be_i,
  output logic [`DM_NR_HARTS-1:0]               debug_req_o,
  output logic [`DM_NR_HARTS-1:0]               halted_o,
  output logic [`DM_NR_HARTS-1:0]               resuming_o,
  output dm_pkg::word_t [`DM_DATA_COUNT-1:0]    data_o,
  output logic                                  data_valid_o,
  output logic                                  cmderror_valid_o,
  output dm_pkg::cmderr_e                       cmderror_o,
  output logic                                  cmdbusy_o,
  output logic [`DM_BUS_WIDTH-1:0]              rdata_o
);
  import dm_pkg::*;

  logic [`DM_HART_BITS-1:0]          hartsel;
  logic [`DM_NR_HARTS-1:0]           halted_set;
  logic [`DM_NR_HARTS-1:0]           resuming_set;
  logic [`DM_NR_HARTS-1:0]           resumeack_clr;
  logic                              going;
  logic                              exception;
  logic                              go;
  logic                              resume;
  logic                              unsupported;
  logic                              jump_progbuf;
  word_t [`DM_ABSCMD_WORDS-1:0]      prog;

  // upper hartsel bits address harts that do not exist
  assign hartsel     = hartsel_i[`DM_HART_BITS-1:0];
  // halt requests go straight to the cores
  assign debug_req_o = haltreq_i;

  dm_mem_decode u_decode (
    .clk_i, .rst_ni, .req_i, .we_i, .addr_i, .wdata_i, .be_i,
    .hartsel_i       (hartsel),
    .clear_resumeack_i, .data_i, .progbuf_i,
    .prog_i          (prog),
    .jump_progbuf_i  (jump_progbuf),
    .cmdbusy_i       (cmdbusy_o),
    .go_i            (go),
    .resume_i        (resume),
    .resumereq_i,
    .halted_set_o    (halted_set),
    .resuming_set_o  (resuming_set),
    .resumeack_clr_o (resumeack_clr),
    .going_o         (going),
    .exception_o     (exception),
    .data_o, .data_valid_o, .rdata_o
  );

  dm_hart_ctrl_fsm u_fsm (
    .clk_i, .rst_ni,
    .hartsel_i     (hartsel),
    .cmd_valid_i,
    .unsupported_i (unsupported),
    .halted_i      (halted_o),
    .halted_set_i  (halted_set),
    .resuming_i    (resuming_o),
    .haltreq_i, .resumereq_i,
    .going_i       (going),
    .exception_i   (exception),
    .cmdbusy_o,
    .go_o          (go),
    .resume_o      (resume),
    .cmderror_valid_o, .cmderror_o
  );

  dm_prog_gen u_prog_gen (
    .cmd_i,
    .prog_o         (prog),
    .unsupported_o  (unsupported),
    .jump_progbuf_o (jump_progbuf)
  );

  // one status pair per hart
  for (genvar h = 0; h < `DM_NR_HARTS; h++) begin : gen_hart
    dm_hart_flags #(.Selectable(1'b1)) u_flags (
      .clk_i, .rst_ni,
      .halted_set_i    (halted_set[h]),
      .resuming_set_i  (resuming_set[h]),
      .resumeack_clr_i (resumeack_clr[h]),
      .halted_o        (halted_o[h]),
      .resuming_o      (resuming_o[h])
    );
  end

endmodule

// ==== test/tb_clk_gen.sv ====
`timescale 1ns/10ps

module tb_clk_gen #(
  parameter int unsigned HalfPeriod  = 5,
  parameter int unsigned ResetCycles = 2
) (
  output logic clk_o,
  output logic rst_no
);

  // 10 ns period
  initial begin
    clk_o = 1'b0;
    forever #(HalfPeriod) clk_o = ~clk_o;
  end

  // reset low for two rising edges, released on a falling edge
  initial begin
    rst_no = 1'b0;
    repeat (ResetCycles) @(posedge clk_o);
    @(negedge clk_o);
    rst_no = 1'b1;
  end

endmodule

// ==== test/tb_dm_mem.sv ====
`timescale 1ns/10ps
`include "dm_consts.svh"

module tb_dm_mem;
  import dm_pkg::*;

  // each of the five directed tests needs well below this many cycles
  localparam int unsigned NumTests      = 5;
  localparam int unsigned CyclesPerTest = 400;
  localparam int unsigned TimeoutCycles = NumTests * CyclesPerTest;
  // hart used for the halt, resume and command sequences
  localparam int unsigned Hart          = 2;

  logic                         clk;
  logic                         rst_n;
  logic [19:0]                  hartsel;
  logic [`DM_NR_HARTS-1:0]      haltreq;
  logic [`DM_NR_HARTS-1:0]      resumereq;
  logic                         clear_resumeack;
  word_t [`DM_PROGBUF_SIZE-1:0] progbuf;
  word_t [`DM_DATA_COUNT-1:0]   data_in;
  logic                         cmd_valid;
  command_t                     cmd;
  logic                         req;
  logic                         we;
  logic [31:0]                  addr;
  logic [31:0]                  wdata;
  logic [3:0]                   be;
  logic [`DM_NR_HARTS-1:0]      debug_req;
  logic [`DM_NR_HARTS-1:0]      halted;
  logic [`DM_NR_HARTS-1:0]      resuming;
  word_t [`DM_DATA_COUNT-1:0]   data_out;
  logic                         data_valid;
  logic                         cmderror_valid;
  cmderr_e                      cmderror;
  logic                         cmdbusy;
  logic [31:0]                  rdata;

  tb_clk_gen u_clk_gen (
    .clk_o  (clk),
    .rst_no (rst_n)
  );

  dm_mem_top u_dut (
    .clk_i             (clk),
    .rst_ni            (rst_n),
    .hartsel_i         (hartsel),
    .haltreq_i         (haltreq),
    .resumereq_i       (resumereq),
    .clear_resumeack_i (clear_resumeack),
    .progbuf_i         (progbuf),
    .data_i            (data_in),
    .cmd_valid_i       (cmd_valid),
    .cmd_i             (cmd),
    .req_i             (req),
    .we_i              (we),
    .addr_i            (addr),
    .wdata_i           (wdata),
    .be_i              (be),
    .debug_req_o       (debug_req),
    .halted_o          (halted),
    .resuming_o        (resuming),
    .data_o            (data_out),
    .data_valid_o      (data_valid),
    .cmderror_valid_o  (cmderror_valid),
    .cmderror_o        (cmderror),
    .cmdbusy_o         (cmdbusy),
    .rdata_o           (rdata)
  );

  // ---------------------------------------------------------------------------
  // expected instruction words built from the rv32 encoding tables
  // ---------------------------------------------------------------------------

  // jal x0 from the whereto slot to target
  function automatic word_t jal_to(input logic [11:0] target);
    logic [20:0] off;
    off = 21'(target) - 21'(`DM_WHERETO_ADDR);
    return {off[20], off[10:1], off[11], off[19:12], 5'd0, 7'b1101111};
  endfunction

  // sw rs2, data0(x0)
  function automatic word_t store_data0(input logic [4:0] rs2);
    logic [11:0] off;
    off = `DM_DATA_ADDR;
    return {off[11:5], rs2, 5'd0, 3'b010, off[4:0], 7'b0100011};
  endfunction

  // access register command of 32 bit size
  function automatic command_t ar_cmd(input logic transfer, input logic write,
                                      input logic [15:0] regno);
    ac_ar_cmd_t ar;
    command_t   c;
    ar          = '0;
    ar.aarsize  = 3'd2;
    ar.transfer = transfer;
    ar.write    = write;
    ar.regno    = regno;
    c.cmdtype   = AccessRegister;
    c.control   = ar;
    return c;
  endfunction

  // ---------------------------------------------------------------------------
  // failure and compare tasks
  // ---------------------------------------------------------------------------

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("CHECKS FAILED");
    $fatal(1, "simulation stopped at %0t", $time);
  endtask

  task automatic check_word(input string name, input word_t got, input word_t exp);
    if (got !== exp) begin
      abort_run($sformatf("ERROR t=%0t %s got=%h exp=%h", $time, name, got, exp));
    end
  endtask

  task automatic check_err(input string name, input cmderr_e got, input cmderr_e exp);
    if (got !== exp) begin
      abort_run($sformatf("ERROR t=%0t %s got=%s exp=%s", $time, name,
                          got.name(), exp.name()));
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      abort_run($sformatf("ERROR t=%0t %s got=%b exp=%b", $time, name, got, exp));
    end
  endtask

  // ---------------------------------------------------------------------------
  // bus helpers that drive on the falling edge
  // ---------------------------------------------------------------------------

  task automatic bus_drive(input logic [11:0] a, input word_t d, input logic [3:0] b,
                           input logic w);
    @(negedge clk);
    req   = 1'b1;
    we    = w;
    addr  = 32'(a);
    wdata = d;
    be    = b;
  endtask

  task automatic bus_release();
    @(negedge clk);
    req = 1'b0;
    we  = 1'b0;
  endtask

  task automatic bus_write(input logic [11:0] a, input word_t d, input logic [3:0] b);
    bus_drive(a, d, b, 1'b1);
    bus_release();
  endtask

  // rdata_o is registered and sampled half a cycle after the capturing edge
  task automatic read_expect(input logic [11:0] a, input word_t exp, input string name);
    bus_drive(a, 32'h0, 4'h0, 1'b0);
    bus_release();
    check_word({"rdata_o ", name}, rdata, exp);
  endtask

  task automatic wait_not_busy(input int unsigned max_cycles);
    int unsigned n;
    n = 0;
    while (cmdbusy && n < max_cycles) begin
      @(negedge clk);
      n++;
    end
    if (cmdbusy) begin
      abort_run("cmdbusy_o did not clear after the hart halted again");
    end
  endtask

  // ---------------------------------------------------------------------------
  // directed tests
  // ---------------------------------------------------------------------------

  task automatic test_reset();
    check_bit("cmdbusy_o", cmdbusy, 1'b0);
    check_word("halted_o", 32'(halted), 32'h0);
    check_word("resuming_o", 32'(resuming), 32'h0);
    check_word("rdata_o", rdata, 32'h0);
    // halt requests pass straight through
    @(negedge clk);
    haltreq = `DM_NR_HARTS'(5);
    #1;
    check_word("debug_req_o", 32'(debug_req), 32'(haltreq));
    @(negedge clk);
    haltreq = '0;
    #1;
    check_word("debug_req_o", 32'(debug_req), 32'h0);
  endtask

  task automatic test_halt_resume();
    @(negedge clk);
    hartsel = 20'(Hart);
    bus_write(`DM_HALTED_ADDR, 32'(Hart), 4'hF);
    check_word("halted_o", 32'(halted), 32'h1 << Hart);
    @(negedge clk);
    resumereq[Hart] = 1'b1;
    // fsm sits in resume
    // hart 2 owns byte 2 of the first flags word
    read_expect(`DM_FLAGS_ADDR, 32'h2 << (8 * Hart), "flags");
    read_expect(`DM_WHERETO_ADDR, jal_to(`DM_RESUME_ADDR), "whereto");
    bus_write(`DM_RESUMING_ADDR, 32'(Hart), 4'hF);
    check_bit("halted_o[2]", halted[Hart], 1'b0);
    check_bit("resuming_o[2]", resuming[Hart], 1'b1);
    @(negedge clk);
    resumereq[Hart] = 1'b0;
    clear_resumeack = 1'b1;
    @(negedge clk);
    clear_resumeack = 1'b0;
    check_bit("resuming_o[2]", resuming[Hart], 1'b0);
  endtask

  task automatic test_gpr_command();
    hartsel = 20'(Hart);
    bus_write(`DM_HALTED_ADDR, 32'(Hart), 4'hF);
    check_bit("halted_o[2]", halted[Hart], 1'b1);
    // read of x8 into data0
    @(negedge clk);
    cmd       = ar_cmd(1'b1, 1'b0, 16'h1008);
    cmd_valid = 1'b1;
    #1;
    check_bit("cmderror_valid_o", cmderror_valid, 1'b0);
    @(negedge clk);
    cmd_valid = 1'b0;
    check_bit("cmdbusy_o", cmdbusy, 1'b1);
    read_expect(`DM_FLAGS_ADDR, 32'h1 << (8 * Hart), "flags");
    read_expect(`DM_WHERETO_ADDR, jal_to(`DM_ABSCMD_ADDR), "whereto");
    read_expect(`DM_ABSCMD_ADDR, 32'h0000_0013, "abstract word 0");
    read_expect(`DM_ABSCMD_ADDR + 12'd4, store_data0(5'd8), "abstract word 1");
    read_expect(`DM_ABSCMD_ADDR + 12'd36, 32'h0010_0073, "abstract word 9");
    bus_write(`DM_GOING_ADDR, 32'h0, 4'hF);
    check_bit("cmdbusy_o", cmdbusy, 1'b1);
    // ebreak at the end brings the hart back to the park loop
    bus_write(`DM_HALTED_ADDR, 32'(Hart), 4'hF);
    wait_not_busy(10);
  endtask

  task automatic test_errors();
    // hart 1 never reported halted
    hartsel = 20'd1;
    @(negedge clk);
    cmd       = ar_cmd(1'b1, 1'b0, 16'h1008);
    cmd_valid = 1'b1;
    #1;
    check_bit("cmderror_valid_o", cmderror_valid, 1'b1);
    check_err("cmderror_o", cmderror, CmdErrHaltResume);
    @(negedge clk);
    cmd_valid = 1'b0;
    check_bit("cmdbusy_o", cmdbusy, 1'b0);
    // csr regno on the halted hart
    @(negedge clk);
    hartsel   = 20'(Hart);
    cmd       = ar_cmd(1'b1, 1'b0, 16'h0300);
    cmd_valid = 1'b1;
    #1;
    check_bit("cmderror_valid_o", cmderror_valid, 1'b1);
    check_err("cmderror_o", cmderror, CmdErrNotSupported);
    @(negedge clk);
    cmd_valid = 1'b0;
    check_bit("cmdbusy_o", cmdbusy, 1'b0);
    bus_drive(`DM_EXCEPTION_ADDR, 32'h0, 4'hF, 1'b1);
    #1;
    check_bit("cmderror_valid_o", cmderror_valid, 1'b1);
    check_err("cmderror_o", cmderror, CmdErrException);
    bus_release();
    #1;
    check_bit("cmderror_valid_o", cmderror_valid, 1'b0);
  endtask

  task automatic test_data_path();
    word_t      wr;
    word_t      exp;
    logic [3:0] mask;
    wr   = $urandom;
    mask = 4'b0101;
    // bytes 0 and 2 come from the write
    exp  = {data_in[1][31:24], wr[23:16], data_in[1][15:8], wr[7:0]};
    bus_drive(`DM_DATA_ADDR + 12'd4, wr, mask, 1'b1);
    #1;
    check_bit("data_valid_o", data_valid, 1'b1);
    check_word("data_o[1]", data_out[1], exp);
    check_word("data_o[0]", data_out[0], data_in[0]);
    bus_release();
    #1;
    check_bit("data_valid_o", data_valid, 1'b0);
    read_expect(`DM_DATA_ADDR, data_in[0], "data word 0");
    read_expect(`DM_DATA_ADDR + 12'd4, data_in[1], "data word 1");
    for (int k = 0; k < `DM_PROGBUF_SIZE; k++) begin
      read_expect(12'(`DM_PROGBUF_ADDR + 4 * k), progbuf[k], "progbuf word");
    end
    // unmapped address keeps the last value
    read_expect(12'h200, progbuf[`DM_PROGBUF_SIZE-1], "unmapped read");
  endtask

  // ---------------------------------------------------------------------------
  // sequencing and watchdog
  // ---------------------------------------------------------------------------

  initial begin : p_main
    void'($urandom(32'h2d5f));
    hartsel         = '0;
    haltreq         = '0;
    resumereq       = '0;
    clear_resumeack = 1'b0;
    cmd_valid       = 1'b0;
    cmd             = '0;
    req             = 1'b0;
    we              = 1'b0;
    addr            = '0;
    wdata           = '0;
    be              = '0;
    for (int i = 0; i < `DM_PROGBUF_SIZE; i++) begin
      progbuf[i] = $urandom;
    end
    for (int i = 0; i < `DM_DATA_COUNT; i++) begin
      data_in[i] = $urandom;
    end
    @(posedge rst_n);
    @(negedge clk);
    test_reset();
    test_halt_resume();
    test_gpr_command();
    test_errors();
    test_data_path();
    $display("ALL CHECKS PASSED");
    $finish;
  end

  initial begin : p_watchdog
    repeat (TimeoutCycles) @(posedge clk);
    abort_run("watchdog expired before the tests finished");
  end

endmodule

// ==== dm_mem.f ====
+incdir+common
common/dm_pkg.sv
hart_ctrl/dm_hart_flags.sv
hart_ctrl/dm_hart_ctrl_fsm.sv
hw/dm_prog_gen.sv
hw/dm_mem_decode.sv
hw/dm_mem_top.sv
test/tb_clk_gen.sv
test/tb_dm_mem.sv

// ==== Makefile ====
# Verilator build and run of the debug memory testbench

VERILATOR ?= verilator
FILELIST  ?= dm_mem.f
TB_TOP    ?= tb_dm_mem
RTL_TOP   ?= dm_mem_top
BUILD_DIR ?= obj_dir
VFLAGS    ?= --timing
PASS_MSG  ?= ALL CHECKS PASSED

SIM_BIN := $(BUILD_DIR)/V$(TB_TOP)

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) \
		--Mdir $(BUILD_DIR) -o V$(TB_TOP)

# status comes from grep, output still shown on stderr
run: build
	./$(SIM_BIN) | tee /dev/stderr | grep -F "$(PASS_MSG)" > /dev/null

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(BUILD_DIR)
